/* rtl/dfr_pkg.sv */
package dfr_pkg;

    localparam int N_NODES     = 8;
    localparam int N_OUT       = 4;
    localparam int MAX_SAMPLES = 16;
    localparam int NODE_W      = 16;
    localparam int ACC_W       = 32;
    localparam int ADDR_W      = 8;
    localparam int WB_DATA_W   = 32;

    localparam int NODE_IDX_W   = $clog2(N_NODES);
    localparam int SAMPLE_IDX_W = $clog2(MAX_SAMPLES);
    localparam int OUT_IDX_W    = $clog2(N_OUT);
    localparam int WEIGHT_IDX_W = $clog2(N_OUT * N_NODES);
    localparam int CNT_W        = SAMPLE_IDX_W + 1;  // Holds a count of MAX_SAMPLES

    // Word addresses
    localparam logic [ADDR_W-1:0] REG_CTRL     = 8'h00;
    localparam logic [ADDR_W-1:0] REG_STATUS   = 8'h01;
    localparam logic [ADDR_W-1:0] REG_INIT_CNT = 8'h02;
    localparam logic [ADDR_W-1:0] REG_MAIN_CNT = 8'h03;
    localparam logic [ADDR_W-1:0] OUT_BASE     = 8'h08;
    localparam logic [ADDR_W-1:0] MASK_BASE    = 8'h10;
    localparam logic [ADDR_W-1:0] SAMPLE_BASE  = 8'h20;
    localparam logic [ADDR_W-1:0] WEIGHT_BASE  = 8'h40;  // Row-major by output

    typedef enum logic [2:0] {
        DONE, RES_INIT, RES_INIT_WAIT, RES_RUN, RES_RUN_WAIT, READOUT
    } ctrl_state_t;

endpackage

/* rtl/dfr_wb_regs.sv */
module dfr_wb_regs import dfr_pkg::*; (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 wb_cyc,
    input  logic                                 wb_stb,
    input  logic                                 wb_we,
    input  logic [ADDR_W-1:0]                    wb_adr,
    input  logic [WB_DATA_W-1:0]                 wb_dat_w,
    output logic [WB_DATA_W-1:0]                 wb_dat_r,
    output logic                                 wb_ack,
    input  logic                                 core_busy,
    input  logic                                 core_done,
    output logic                                 start,
    output logic [CNT_W-1:0]                     init_cnt,
    output logic [CNT_W-1:0]                     main_cnt,
    input  logic [SAMPLE_IDX_W-1:0]              sample_idx,
    output logic [NODE_W-1:0]                    sample,
    input  logic [NODE_IDX_W-1:0]                node_idx,
    output logic [NODE_W-1:0]                    mask,
    input  logic [NODE_IDX_W-1:0]                weight_idx,
    output logic [N_OUT-1:0][NODE_W-1:0]         weight_row,
    input  logic [N_OUT-1:0][ACC_W-1:0]          out_sums,
    input  logic                                 out_valid
);
    logic [NODE_W-1:0] mask_mem   [N_NODES];
    logic [NODE_W-1:0] sample_mem [MAX_SAMPLES];
    logic [NODE_W-1:0] weight_mem [N_OUT * N_NODES];
    logic [ACC_W-1:0]  out_q      [N_OUT];
    logic [ADDR_W-1:0] mask_off, sample_off, weight_off, out_off;
    logic              in_mask, in_sample, in_weight, in_out;
    logic              req, wr, mem_wr;

    assign req    = wb_cyc && wb_stb && !wb_ack;  // One ack per strobe
    assign wr     = req && wb_we;
    assign mem_wr = wr && !core_busy;

    // Offsets wrap below the base, so one compare checks both ends of a window
    assign mask_off   = wb_adr - MASK_BASE;
    assign sample_off = wb_adr - SAMPLE_BASE;
    assign weight_off = wb_adr - WEIGHT_BASE;
    assign out_off    = wb_adr - OUT_BASE;
    assign in_mask    = mask_off < ADDR_W'(N_NODES);
    assign in_sample  = sample_off < ADDR_W'(MAX_SAMPLES);
    assign in_weight  = weight_off < ADDR_W'(N_OUT * N_NODES);
    assign in_out     = out_off < ADDR_W'(N_OUT);

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack   <= 1'b0;
            start    <= 1'b0;
            init_cnt <= '0;
            main_cnt <= '0;
        end else begin
            wb_ack <= req;
            start  <= wr && wb_adr == REG_CTRL && wb_dat_w[0] && !core_busy;
            if (mem_wr && wb_adr == REG_INIT_CNT) init_cnt <= wb_dat_w[CNT_W-1:0];
            if (mem_wr && wb_adr == REG_MAIN_CNT) main_cnt <= wb_dat_w[CNT_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wr && in_mask) mask_mem[mask_off[NODE_IDX_W-1:0]] <= wb_dat_w[NODE_W-1:0];
        if (mem_wr && in_sample) begin
            sample_mem[sample_off[SAMPLE_IDX_W-1:0]] <= wb_dat_w[NODE_W-1:0];
        end
        if (mem_wr && in_weight) begin
            weight_mem[weight_off[WEIGHT_IDX_W-1:0]] <= wb_dat_w[NODE_W-1:0];
        end
        if (out_valid) begin
            for (int j = 0; j < N_OUT; j++) out_q[j] <= out_sums[j];
        end
    end

    assign sample = sample_mem[sample_idx];
    assign mask   = mask_mem[node_idx];

    always_comb begin
        for (int j = 0; j < N_OUT; j++) weight_row[j] = weight_mem[j * N_NODES + int'(weight_idx)];
    end

    always_comb begin
        wb_dat_r = '0;
        if (wb_ack) begin
            if (wb_adr == REG_STATUS) wb_dat_r = WB_DATA_W'({core_done, core_busy});
            else if (wb_adr == REG_INIT_CNT) wb_dat_r = WB_DATA_W'(init_cnt);
            else if (wb_adr == REG_MAIN_CNT) wb_dat_r = WB_DATA_W'(main_cnt);
            else if (in_out) wb_dat_r = WB_DATA_W'(out_q[out_off[OUT_IDX_W-1:0]]);
            else if (in_mask) wb_dat_r = WB_DATA_W'(mask_mem[mask_off[NODE_IDX_W-1:0]]);
            else if (in_sample) begin
                wb_dat_r = WB_DATA_W'(sample_mem[sample_off[SAMPLE_IDX_W-1:0]]);
            end else if (in_weight) begin
                wb_dat_r = WB_DATA_W'(weight_mem[weight_off[WEIGHT_IDX_W-1:0]]);
            end
        end
    end

    a_ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack);

endmodule

/* rtl/dfr_core_controller.sv */
module dfr_core_controller import dfr_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic        res_init_busy,
    input  logic        res_busy,
    input  logic        res_valid,
    input  logic        res_filled,
    input  logic        readout_busy,
    output logic        core_busy,
    output logic        core_done,
    output logic        res_en,
    output logic        res_clr,
    output logic        sample_cnt_en,
    output logic        init_cnt_en,
    output logic        history_en,
    output logic        readout_start,
    output ctrl_state_t state
);
    ctrl_state_t next_state;

    always_ff @(posedge clk) begin
        if (rst) state <= DONE;
        else state <= next_state;
    end

    always_comb begin
        next_state    = state;
        core_busy     = 1'b1;
        core_done     = 1'b0;
        res_en        = 1'b0;
        res_clr       = 1'b0;
        sample_cnt_en = 1'b0;
        init_cnt_en   = 1'b0;
        history_en    = 1'b0;
        readout_start = 1'b0;

        case (state)
            DONE: begin
                core_busy = 1'b0;
                if (start) begin
                    res_clr    = 1'b1;  // Nodes, counters and history start from zero
                    next_state = RES_INIT;
                end else begin
                    core_done = 1'b1;
                end
            end
            RES_INIT: begin
                if (res_init_busy) begin
                    res_en     = 1'b1;
                    next_state = RES_INIT_WAIT;
                end else begin
                    next_state = RES_RUN;
                end
            end
            RES_INIT_WAIT: begin
                if (res_valid) begin
                    sample_cnt_en = 1'b1;
                    init_cnt_en   = 1'b1;
                    next_state    = RES_INIT;
                end
            end
            RES_RUN: begin
                history_en = res_filled;  // Nodes are idle here, so the copy is coherent
                if (res_busy) begin
                    res_en     = 1'b1;
                    next_state = RES_RUN_WAIT;
                end else begin
                    readout_start = 1'b1;
                    next_state    = READOUT;
                end
            end
            RES_RUN_WAIT: begin
                if (res_valid) begin
                    sample_cnt_en = 1'b1;
                    next_state    = RES_RUN;
                end
            end
            READOUT: begin
                if (!readout_busy) next_state = DONE;
            end
            default: next_state = DONE;
        endcase
    end

    a_start_in_run: assert property (@(posedge clk) disable iff (rst)
        readout_start |-> state == RES_RUN && !readout_busy);
    a_en_not_clr: assert property (@(posedge clk) disable iff (rst) !(res_en && res_clr));

endmodule

/* rtl/dfr_reservoir.sv */
module dfr_reservoir import dfr_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          res_clr,
    input  logic                          res_en,
    input  logic                          sample_cnt_en,
    input  logic                          init_cnt_en,
    input  logic                          history_en,
    input  logic [CNT_W-1:0]              init_cnt,
    input  logic [CNT_W-1:0]              main_cnt,
    input  logic [NODE_W-1:0]             sample,
    input  logic [NODE_W-1:0]             mask,
    output logic [SAMPLE_IDX_W-1:0]       sample_idx,
    output logic [NODE_IDX_W-1:0]         node_idx,
    output logic                          res_init_busy,
    output logic                          res_busy,
    output logic                          res_valid,
    output logic                          res_filled,
    output logic [N_NODES-1:0][NODE_W-1:0] history
);
    logic signed [NODE_W-1:0]   node_mem [N_NODES];
    logic                       running;
    logic [NODE_IDX_W-1:0]      step;
    logic [CNT_W-1:0]           sample_cnt, init_done, main_done;
    logic signed [2*NODE_W-1:0] prod;
    logic signed [2*NODE_W:0]   prod_ext, old_ext, pre_sat;
    logic signed [NODE_W-1:0]   node_new;

    always_ff @(posedge clk) begin
        if (rst || res_clr) begin
            running <= 1'b0;
            step    <= '0;
        end else if (res_en) begin
            running <= 1'b1;
            step    <= '0;
        end else if (running) begin
            running <= step != NODE_IDX_W'(N_NODES - 1);
            step    <= step + 1'b1;
        end
    end

    assign res_valid = running && step == NODE_IDX_W'(N_NODES - 1);
    assign node_idx  = step;

    always_ff @(posedge clk) begin
        if (rst || res_clr) begin
            sample_cnt <= '0;
            init_done  <= '0;
        end else begin
            if (sample_cnt_en) sample_cnt <= sample_cnt + 1'b1;
            if (init_cnt_en) init_done <= init_done + 1'b1;
        end
    end

    assign main_done     = sample_cnt - init_done;
    assign sample_idx    = sample_cnt[SAMPLE_IDX_W-1:0];
    assign res_init_busy = init_done < init_cnt;
    assign res_busy      = main_done < main_cnt;
    assign res_filled    = main_done != '0;

    // mask*u >>> 4 plus half the old node, saturated to the node width
    assign prod     = $signed(mask) * $signed(sample);
    assign prod_ext = prod;
    assign old_ext  = node_mem[step];
    assign pre_sat  = (prod_ext >>> 4) + (old_ext >>> 1);

    always_comb begin
        if (pre_sat[2*NODE_W:NODE_W-1] == '0 || pre_sat[2*NODE_W:NODE_W-1] == '1) begin
            node_new = pre_sat[NODE_W-1:0];
        end else if (pre_sat[2*NODE_W]) begin
            node_new = {1'b1, {(NODE_W-1){1'b0}}};
        end else begin
            node_new = {1'b0, {(NODE_W-1){1'b1}}};
        end
    end

    always_ff @(posedge clk) begin
        if (res_clr) begin
            for (int k = 0; k < N_NODES; k++) node_mem[k] <= '0;
            history <= '0;
        end else begin
            if (running) node_mem[step] <= node_new;
            if (history_en) begin
                for (int k = 0; k < N_NODES; k++) history[k] <= node_mem[k];
            end
        end
    end

    a_valid_after_en: assert property (@(posedge clk) disable iff (rst)
        res_valid |-> $past(res_en, N_NODES));

endmodule

/* rtl/dfr_readout.sv */
module dfr_readout import dfr_pkg::*; (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           readout_start,
    input  logic [N_NODES-1:0][NODE_W-1:0] history,
    input  logic [N_OUT-1:0][NODE_W-1:0]   weight_row,
    output logic [NODE_IDX_W-1:0]          weight_idx,
    output logic                           readout_busy,
    output logic [N_OUT-1:0][ACC_W-1:0]    out_sums,
    output logic                           out_valid
);
    logic [NODE_IDX_W:0]   step;  // One extra count drains the lane product register
    logic                  last;
    logic                  lane_en;
    logic [NODE_W-1:0]     node;

    assign last       = step == (NODE_IDX_W + 1)'(N_NODES);
    assign lane_en    = readout_busy && !last;
    assign weight_idx = step[NODE_IDX_W-1:0];
    assign node       = history[weight_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            readout_busy <= 1'b0;
            step         <= '0;
            out_valid    <= 1'b0;
        end else begin
            out_valid <= readout_busy && last;  // Final accumulate lands on this edge
            if (readout_start) begin
                readout_busy <= 1'b1;
                step         <= '0;
            end else if (readout_busy) begin
                if (last) readout_busy <= 1'b0;
                step <= step + 1'b1;
            end
        end
    end

    // Each lane sees the same history node with its own weight
    for (genvar j = 0; j < N_OUT; j++) begin : g_lane
        dfr_mac_lane u_lane (
            .clk    (clk),
            .rst    (rst),
            .clr    (readout_start),
            .en     (lane_en),
            .node   (node),
            .weight (weight_row[j]),
            .sum    (out_sums[j])
        );
    end

endmodule

/* rtl/dfr_mac_lane.sv */
module dfr_mac_lane import dfr_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              clr,
    input  logic              en,
    input  logic [NODE_W-1:0] node,
    input  logic [NODE_W-1:0] weight,
    output logic [ACC_W-1:0]  sum
);
    logic signed [2*NODE_W-1:0] prod_q;
    logic                       prod_vld;

    always_ff @(posedge clk) begin
        prod_q <= $signed(node) * $signed(weight);
    end

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            prod_vld <= 1'b0;
            sum      <= '0;
        end else begin
            prod_vld <= en;
            if (prod_vld) sum <= sum + ACC_W'(prod_q);  // Wraps on overflow
        end
    end

endmodule

/* rtl/dfr_top.sv */
module dfr_top import dfr_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [ADDR_W-1:0]    wb_adr,
    input  logic [WB_DATA_W-1:0] wb_dat_w,
    output logic [WB_DATA_W-1:0] wb_dat_r,
    output logic                 wb_ack
);
    logic                           start, core_busy, core_done;
    logic                           res_en, res_clr, sample_cnt_en, init_cnt_en, history_en;
    logic                           res_init_busy, res_busy, res_valid, res_filled;
    logic                           readout_start, readout_busy, out_valid;
    logic [CNT_W-1:0]               init_cnt, main_cnt;
    logic [SAMPLE_IDX_W-1:0]        sample_idx;
    logic [NODE_IDX_W-1:0]          node_idx, weight_idx;
    logic [NODE_W-1:0]              sample, mask;
    logic [N_OUT-1:0][NODE_W-1:0]   weight_row;
    logic [N_NODES-1:0][NODE_W-1:0] history;
    logic [N_OUT-1:0][ACC_W-1:0]    out_sums;

    dfr_wb_regs u_regs (.*);

    // The state output is there for debug probing only
    dfr_core_controller u_ctrl (
        .*,
        .state ()
    );

    dfr_reservoir u_res (.*);

    dfr_readout u_readout (.*);

endmodule

/* dv/dfr_tb.sv */
module dfr_tb import dfr_pkg::*; ();

    localparam int     N_CASES     = 9;
    localparam int     BUS_LIMIT   = 20;   // Cycles to wait for one ack
    localparam int     POLL_LIMIT  = 400;
    localparam int     KIND_FIXED  = 0;
    localparam int     KIND_RANDOM = 1;
    localparam int     KIND_LARGE  = 2;
    localparam longint NODE_MAX    = 2 ** (NODE_W - 1) - 1;
    localparam longint NODE_MIN    = -(2 ** (NODE_W - 1));

    // Each array holds one column of the case table and one entry per case
    localparam int CASE_INIT [N_CASES] = '{0, 3, 2, 3, 4, 1, 5, 0, 7};
    localparam int CASE_MAIN [N_CASES] = '{1, 2, 3, 0, 8, 5, 11, 16, 2};
    localparam int CASE_KIND [N_CASES] = '{KIND_FIXED, KIND_FIXED, KIND_LARGE, KIND_FIXED,
                                           KIND_FIXED, KIND_RANDOM, KIND_RANDOM, KIND_RANDOM,
                                           KIND_RANDOM};
    localparam bit CASE_PROBE [N_CASES] = '{0, 0, 0, 0, 1, 0, 0, 0, 0};

    logic                     clk, rst;
    logic                     wb_cyc, wb_stb, wb_we, wb_ack;
    logic [ADDR_W-1:0]        wb_adr;
    logic [WB_DATA_W-1:0]     wb_dat_w, wb_dat_r;
    logic signed [NODE_W-1:0] mask_ref   [N_NODES];
    logic signed [NODE_W-1:0] sample_ref [MAX_SAMPLES];
    logic signed [NODE_W-1:0] weight_ref [N_OUT * N_NODES];
    logic [ACC_W-1:0]         sum_ref    [N_OUT];
    int                       n_checks, n_errors;
    bit                       timed_out;

    dfr_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic bus_cycle(input logic we, input logic [ADDR_W-1:0] adr,
                             input logic [WB_DATA_W-1:0] wdata,
                             output logic [WB_DATA_W-1:0] rdata);
        int waited;
        rdata = '0;
        if (timed_out) return;
        @(posedge clk);
        #1;
        {wb_cyc, wb_stb, wb_we} = {1'b1, 1'b1, we};
        wb_adr   = adr;
        wb_dat_w = wdata;
        waited   = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!wb_ack && waited < BUS_LIMIT);
        if (wb_ack) begin
            rdata = wb_dat_r;
        end else begin
            $display("Bus access to address %h got no ack in %0d cycles", adr, BUS_LIMIT);
            n_errors++;
            timed_out = 1'b1;
        end
        {wb_cyc, wb_stb, wb_we} = 3'b000;
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] adr, input logic [WB_DATA_W-1:0] data);
        logic [WB_DATA_W-1:0] ignored;
        bus_cycle(1'b1, adr, data, ignored);
    endtask

    task automatic bus_read(input logic [ADDR_W-1:0] adr, output logic [WB_DATA_W-1:0] data);
        bus_cycle(1'b0, adr, '0, data);
    endtask

    task automatic check_word(input string name, input logic [WB_DATA_W-1:0] got,
                              input logic [WB_DATA_W-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERR %s exp=%h got=%h", name, exp, got);
        end
    endtask

    task automatic check_sum(input string name, input logic [ACC_W-1:0] got,
                             input logic [ACC_W-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERR %s exp=%h got=%h", name, exp, got);
        end
    endtask

    function automatic logic signed [NODE_W-1:0] saturate(input longint v);
        if (v > NODE_MAX) return NODE_W'(NODE_MAX);
        if (v < NODE_MIN) return NODE_W'(NODE_MIN);
        return NODE_W'(v);
    endfunction

    task automatic fill_data(input int kind);
        for (int k = 0; k < N_NODES; k++) begin
            if (kind == KIND_RANDOM) mask_ref[k] = NODE_W'($urandom());
            else if (kind == KIND_LARGE) mask_ref[k] = (k % 2 == 1) ? 16'sh7fff : 16'sh8000;
            else mask_ref[k] = NODE_W'(k * 37 - 100);
        end
        for (int s = 0; s < MAX_SAMPLES; s++) begin
            if (kind == KIND_RANDOM) sample_ref[s] = NODE_W'($urandom());
            else if (kind == KIND_LARGE) sample_ref[s] = (s % 2 == 1) ? 16'sh8000 : 16'sh7ff0;
            else sample_ref[s] = NODE_W'(s * 100 - 500);
        end
        for (int i = 0; i < N_OUT * N_NODES; i++) begin
            if (kind == KIND_RANDOM) weight_ref[i] = NODE_W'($urandom());
            else if (kind == KIND_LARGE) weight_ref[i] = (i % 3 == 0) ? 16'sh8001 : 16'sh7fff;
            else weight_ref[i] = NODE_W'(i * 53 - 700);
        end
    endtask

    // Nodes start at zero and every warm-up or main sample steps them
    task automatic predict_sums(input int init_n, input int main_n);
        longint           node [N_NODES];
        longint           prod;
        logic [ACC_W-1:0] acc;
        for (int k = 0; k < N_NODES; k++) node[k] = 0;
        for (int s = 0; s < init_n + main_n; s++) begin
            for (int k = 0; k < N_NODES; k++) begin
                prod    = longint'(mask_ref[k]) * longint'(sample_ref[s]);
                node[k] = saturate((prod >>> 4) + (node[k] >>> 1));
            end
        end
        if (main_n == 0) begin
            for (int k = 0; k < N_NODES; k++) node[k] = 0;  // No snapshot was taken
        end
        for (int j = 0; j < N_OUT; j++) begin
            acc = '0;
            for (int k = 0; k < N_NODES; k++) begin
                acc = acc + ACC_W'(longint'(weight_ref[j * N_NODES + k]) * node[k]);
            end
            sum_ref[j] = acc;
        end
    endtask

    task automatic load_case(input int init_n, input int main_n);
        for (int k = 0; k < N_NODES; k++) begin
            bus_write(MASK_BASE + ADDR_W'(k), WB_DATA_W'(mask_ref[k]));
        end
        for (int s = 0; s < MAX_SAMPLES; s++) begin
            bus_write(SAMPLE_BASE + ADDR_W'(s), WB_DATA_W'(sample_ref[s]));
        end
        for (int i = 0; i < N_OUT * N_NODES; i++) begin
            bus_write(WEIGHT_BASE + ADDR_W'(i), WB_DATA_W'(weight_ref[i]));
        end
        bus_write(REG_INIT_CNT, WB_DATA_W'(init_n));
        bus_write(REG_MAIN_CNT, WB_DATA_W'(main_n));
    endtask

    task automatic wait_done(input int c);
        logic [WB_DATA_W-1:0] status;
        int                   polls;
        polls = 0;
        do begin
            bus_read(REG_STATUS, status);
            polls++;
        end while (!timed_out && status[1:0] != 2'b10 && polls < POLL_LIMIT);
        if (!timed_out && status[1:0] != 2'b10) begin
            $display("Case %0d did not finish within %0d status polls", c, POLL_LIMIT);
            n_errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_case(input int c);
        logic [WB_DATA_W-1:0] rdata;
        fill_data(CASE_KIND[c]);
        predict_sums(CASE_INIT[c], CASE_MAIN[c]);
        load_case(CASE_INIT[c], CASE_MAIN[c]);
        bus_write(REG_CTRL, WB_DATA_W'(1));
        if (CASE_PROBE[c]) begin
            bus_read(REG_STATUS, rdata);
            check_word("status during run", rdata, WB_DATA_W'(1));
            bus_write(WEIGHT_BASE, ~WB_DATA_W'(weight_ref[0]));  // Must be dropped while busy
        end
        wait_done(c);
        if (timed_out) return;
        for (int j = 0; j < N_OUT; j++) begin
            bus_read(OUT_BASE + ADDR_W'(j), rdata);
            check_sum($sformatf("out_sums[%0d] case %0d", j, c), ACC_W'(rdata), sum_ref[j]);
        end
        if (CASE_PROBE[c]) begin
            bus_read(WEIGHT_BASE, rdata);
            check_word("weight[0]", rdata, WB_DATA_W'($unsigned(weight_ref[0])));
        end
    endtask

    initial begin
        logic [WB_DATA_W-1:0] rdata;
        {n_checks, n_errors, timed_out} = '0;
        {wb_cyc, wb_stb, wb_we} = 3'b000;
        wb_adr   = '0;
        wb_dat_w = '0;
        rst      = 1'b1;
        void'($urandom(32'h68a5_5a9c));
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        bus_read(REG_STATUS, rdata);
        check_word("status after reset", rdata, WB_DATA_W'(2));
        bus_write(REG_MAIN_CNT, WB_DATA_W'(9));
        bus_read(REG_MAIN_CNT, rdata);
        check_word("main_cnt", rdata, WB_DATA_W'(9));
        bus_write(MASK_BASE, 32'hffff_beef);
        bus_read(MASK_BASE, rdata);
        check_word("mask[0]", rdata, 32'h0000_beef);  // Memories hold 16 bits
        for (int c = 0; c < N_CASES && !timed_out; c++) run_case(c);
        $display("Checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
rtl/dfr_pkg.sv
rtl/dfr_wb_regs.sv
rtl/dfr_core_controller.sv
rtl/dfr_reservoir.sv
rtl/dfr_readout.sv
rtl/dfr_mac_lane.sv
rtl/dfr_top.sv
dv/dfr_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := dfr_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := SIMULATION FAILED
PASS_MSG  := SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@! grep -q "$(FAIL_MSG)" $(LOG) && grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
